//--- alu.sv
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    equal
);

    word_t sum;
    word_t diff;

    assign sum  = a + b;
    assign diff = a - b;

    // only add and subtract are needed by the subset
    always_comb begin
        case (op)
            ALU_SUB: result = diff;
            default: result = sum;
        endcase
    end

    // BEQ compare
    assign equal = (a == b);

endmodule

//--- apb_mem.sv
`timescale 1ns/1ns

module apb_mem import cpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      start,
    input  logic      running,
    input  logic      halted,
    input  word_t     pc,
    input  mem_idx_t  imem_addr,
    output word_t     imem_rdata,
    input  mem_idx_t  dmem_addr,
    input  logic      dmem_we,
    input  word_t     dmem_wdata,
    output word_t     dmem_rdata
);

    word_t    imem [MEM_WORDS];
    word_t    dmem [MEM_WORDS];
    logic     access;
    logic     imem_sel;
    logic     dmem_sel;
    logic     mem_blocked;
    logic     apb_wr;
    mem_idx_t apb_idx;

    assign access   = psel && penable;
    assign imem_sel = (paddr[11:8] == ADDR_IMEM_BASE[11:8]);
    assign dmem_sel = (paddr[11:8] == ADDR_DMEM_BASE[11:8]);
    assign apb_idx  = paddr[7:2];

    // memories belong to the core while it runs
    assign mem_blocked = running && (imem_sel || dmem_sel);
    assign apb_wr      = access && pwrite && !mem_blocked;

    assign pready  = 1'b1;
    assign pslverr = access && mem_blocked;

    always_comb begin
        prdata = '0;
        if (imem_sel) begin
            prdata = imem[apb_idx];
        end else if (dmem_sel) begin
            prdata = dmem[apb_idx];
        end else if (paddr == ADDR_STATUS) begin
            prdata = {30'd0, running, halted};
        end else if (paddr == ADDR_PC) begin
            prdata = pc;
        end
    end

    // start pulse, one cycle after the CTRL write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start <= 1'b0;
        end else begin
            start <= access && pwrite && (paddr == ADDR_CTRL) && pwdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (apb_wr && imem_sel) begin
            imem[apb_idx] <= pwdata;
        end
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end else if (apb_wr && dmem_sel) begin
            dmem[apb_idx] <= pwdata;
        end
    end

    assign imem_rdata = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_addr];

    a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> psel);

endmodule

//--- compile.f
cpu_pkg.sv
decoder.sv
reg_file.sv
alu.sv
mul_unit.sv
core_ctrl.sv
apb_mem.sv
cpu_top.sv
tb_cpu.sv

//--- core_ctrl.sv
`timescale 1ns/1ns

module core_ctrl import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    output logic     running,
    output logic     halted,
    output word_t    pc,
    output mem_idx_t imem_addr,
    input  word_t    imem_rdata,
    output mem_idx_t dmem_addr,
    output logic     dmem_we,
    output word_t    dmem_wdata,
    input  word_t    dmem_rdata,
    output word_t    instr,
    dec_if.rcv       dec,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output reg_idx_t wr_idx,
    output logic     wr_en,
    output word_t    wr_data,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output alu_op_e  alu_op,
    output word_t    alu_a,
    output word_t    alu_b,
    input  word_t    alu_result,
    input  logic     alu_equal,
    output alu_op_e  pc_alu_op,
    output word_t    pc_alu_a,
    output word_t    pc_alu_b,
    input  word_t    pc_alu_result,
    mul_if.mst       mul
);

    ctrl_state_e state;
    word_t       res_q;
    logic        is_halt;
    logic        taken;
    logic        writes_rd;

    assign running = (state != ST_IDLE) && (state != ST_HALT);
    assign halted  = (state == ST_HALT);

    // a JAL to itself with no link ends the program
    assign is_halt = (instr == {25'd0, OPCODE_JUMP});

    assign taken = (dec.instr_type == ITYPE_JUMP) ||
                   (dec.instr_type == ITYPE_BRANCH && dec.funct3 == BEQ_FUNCT3 && alu_equal);

    always_comb begin
        case (dec.instr_type)
            ITYPE_ALU, ITYPE_ALU_IMM, ITYPE_MUL, ITYPE_LOAD, ITYPE_JUMP, ITYPE_AUIPC:
                writes_rd = 1'b1;
            default:
                writes_rd = 1'b0;
        endcase
    end

    // data path operand select
    always_comb begin
        alu_op = ALU_ADD;
        alu_a  = rs1_data;
        alu_b  = dec.imm;
        case (dec.instr_type)
            ITYPE_ALU: begin
                alu_b = rs2_data;
                if (dec.funct7 == SUB_FUNCT7) begin
                    alu_op = ALU_SUB;
                end
            end
            ITYPE_BRANCH: alu_b = rs2_data;
            ITYPE_AUIPC:  alu_a = pc;
            ITYPE_JUMP: begin
                // link value
                alu_a = pc;
                alu_b = 32'd4;
            end
            default: alu_a = rs1_data;
        endcase
    end

    assign pc_alu_op = ALU_ADD;
    assign pc_alu_a  = pc;
    assign pc_alu_b  = taken ? dec.imm : 32'd4;

    assign imem_addr = pc[7:2];
    assign rs1_idx   = dec.rs1;
    assign rs2_idx   = dec.rs2;
    assign wr_idx    = dec.rd;
    assign wr_en     = (state == ST_WB) && writes_rd;
    assign wr_data   = res_q;

    // res_q holds the address during ST_MEM
    assign dmem_addr  = res_q[7:2];
    assign dmem_we    = (state == ST_MEM) && (dec.instr_type == ITYPE_STORE);
    assign dmem_wdata = rs2_data;

    assign mul.start = (state == ST_EXEC) && (dec.instr_type == ITYPE_MUL);
    assign mul.op_a  = rs1_data;
    assign mul.op_b  = rs2_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_HALT: begin
                    if (start) begin
                        state <= ST_FETCH;
                        pc    <= '0;
                    end
                end
                ST_FETCH: state <= ST_EXEC;
                ST_EXEC: begin
                    if (is_halt) begin
                        state <= ST_HALT;
                    end else begin
                        pc <= pc_alu_result;
                        case (dec.instr_type)
                            ITYPE_LOAD, ITYPE_STORE: state <= ST_MEM;
                            ITYPE_MUL:               state <= ST_MUL_WAIT;
                            default:                 state <= ST_WB;
                        endcase
                    end
                end
                ST_MEM: state <= ST_WB;
                ST_MUL_WAIT: begin
                    if (mul.done) begin
                        state <= ST_WB;
                    end
                end
                ST_WB:   state <= ST_FETCH;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FETCH) begin
            instr <= imem_rdata;
        end
        if (state == ST_EXEC) begin
            res_q <= alu_result;
        end
        if (state == ST_MEM && dec.instr_type == ITYPE_LOAD) begin
            res_q <= dmem_rdata;
        end
        if (state == ST_MUL_WAIT && mul.done) begin
            res_q <= mul.product;
        end
    end

    // a data memory write comes only from a store opcode in ST_MEM
    a_we_in_mem: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |-> (state == ST_MEM) && (instr[6:0] == OPCODE_STORE));

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  mem_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [11:0] apb_addr_t;

    localparam int NUM_REGS  = 32;
    localparam int MEM_WORDS = 64;
    localparam int MUL_STEPS = 32;

    // down-counter wide enough to hold MUL_STEPS itself
    typedef logic [$clog2(MUL_STEPS + 1) - 1:0] mul_cnt_t;

    // base opcodes of the supported RV32 subset
    localparam opcode_t OPCODE_ALU     = 7'b0110011;
    localparam opcode_t OPCODE_ALU_IMM = 7'b0010011;
    localparam opcode_t OPCODE_LOAD    = 7'b0000011;
    localparam opcode_t OPCODE_STORE   = 7'b0100011;
    localparam opcode_t OPCODE_BRANCH  = 7'b1100011;
    localparam opcode_t OPCODE_JUMP    = 7'b1101111;
    localparam opcode_t OPCODE_AUIPC   = 7'b0010111;

    localparam logic [6:0] MUL_FUNCT7 = 7'b0000001;
    localparam logic [6:0] SUB_FUNCT7 = 7'b0100000;
    localparam logic [2:0] BEQ_FUNCT3 = 3'b000;

    // APB byte address map
    localparam apb_addr_t ADDR_IMEM_BASE = 12'h000;
    localparam apb_addr_t ADDR_DMEM_BASE = 12'h100;
    localparam apb_addr_t ADDR_CTRL      = 12'h200;
    localparam apb_addr_t ADDR_STATUS    = 12'h204;
    localparam apb_addr_t ADDR_PC        = 12'h208;

    typedef enum logic [3:0] {
        ITYPE_ALU,
        ITYPE_ALU_IMM,
        ITYPE_MUL,
        ITYPE_LOAD,
        ITYPE_STORE,
        ITYPE_BRANCH,
        ITYPE_JUMP,
        ITYPE_AUIPC,
        ITYPE_NONE
    } instr_type_e;

    typedef enum logic {
        ALU_ADD,
        ALU_SUB
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_MUL_WAIT,
        ST_WB,
        ST_HALT
    } ctrl_state_e;

endpackage

//--- cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr
);

    logic     start;
    logic     running;
    logic     halted;
    word_t    pc;
    mem_idx_t imem_addr;
    word_t    imem_rdata;
    mem_idx_t dmem_addr;
    logic     dmem_we;
    word_t    dmem_wdata;
    word_t    dmem_rdata;
    word_t    instr;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t wr_idx;
    logic     wr_en;
    word_t    wr_data;
    word_t    rs1_data;
    word_t    rs2_data;
    alu_op_e  alu_op;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_equal;
    alu_op_e  pc_alu_op;
    word_t    pc_alu_a;
    word_t    pc_alu_b;
    word_t    pc_alu_result;

    dec_if dec ();
    mul_if mul ();

    apb_mem u_apb_mem (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .start      (start),
        .running    (running),
        .halted     (halted),
        .pc         (pc),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    core_ctrl u_core_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .start         (start),
        .running       (running),
        .halted        (halted),
        .pc            (pc),
        .imem_addr     (imem_addr),
        .imem_rdata    (imem_rdata),
        .dmem_addr     (dmem_addr),
        .dmem_we       (dmem_we),
        .dmem_wdata    (dmem_wdata),
        .dmem_rdata    (dmem_rdata),
        .instr         (instr),
        .dec           (dec.rcv),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .wr_idx        (wr_idx),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .alu_op        (alu_op),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_result    (alu_result),
        .alu_equal     (alu_equal),
        .pc_alu_op     (pc_alu_op),
        .pc_alu_a      (pc_alu_a),
        .pc_alu_b      (pc_alu_b),
        .pc_alu_result (pc_alu_result),
        .mul           (mul.mst)
    );

    decoder u_decoder (
        .instr (instr),
        .dec   (dec.drv)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .wr_idx   (wr_idx),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // data path ALU
    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .equal  (alu_equal)
    );

    // next PC, its compare output has no use
    alu u_pc_alu (
        .op     (pc_alu_op),
        .a      (pc_alu_a),
        .b      (pc_alu_b),
        .result (pc_alu_result),
        .equal  ()
    );

    mul_unit u_mul_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .mul    (mul.slv)
    );

endmodule

//--- decoder.sv
`timescale 1ns/1ns

interface dec_if import cpu_pkg::*; ();
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    word_t       imm;
    instr_type_e instr_type;
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    modport drv (output rs1, rs2, rd, imm, instr_type, funct3, funct7);
    modport rcv (input  rs1, rs2, rd, imm, instr_type, funct3, funct7);
endinterface

module decoder import cpu_pkg::*; (
    input  word_t     instr,
    dec_if.drv        dec
);

    opcode_t opcode;
    word_t   i_imm;
    word_t   s_imm;
    word_t   b_imm;
    word_t   u_imm;
    word_t   j_imm;

    assign opcode     = instr[6:0];
    assign dec.rd     = instr[11:7];
    assign dec.funct3 = instr[14:12];
    assign dec.rs1    = instr[19:15];
    assign dec.rs2    = instr[24:20];
    assign dec.funct7 = instr[31:25];

    // immediates per format, sign bit is always instr[31]
    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'd0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec.instr_type = ITYPE_NONE;
        dec.imm        = '0;
        case (opcode)
            OPCODE_ALU: begin
                // R type shares one opcode, MUL is told apart by funct7
                if (dec.funct7 == MUL_FUNCT7) begin
                    dec.instr_type = ITYPE_MUL;
                end else begin
                    dec.instr_type = ITYPE_ALU;
                end
            end
            OPCODE_ALU_IMM: begin
                dec.instr_type = ITYPE_ALU_IMM;
                dec.imm        = i_imm;
            end
            OPCODE_LOAD: begin
                dec.instr_type = ITYPE_LOAD;
                dec.imm        = i_imm;
            end
            OPCODE_STORE: begin
                dec.instr_type = ITYPE_STORE;
                dec.imm        = s_imm;
            end
            OPCODE_BRANCH: begin
                dec.instr_type = ITYPE_BRANCH;
                dec.imm        = b_imm;
            end
            OPCODE_JUMP: begin
                dec.instr_type = ITYPE_JUMP;
                dec.imm        = j_imm;
            end
            OPCODE_AUIPC: begin
                dec.instr_type = ITYPE_AUIPC;
                dec.imm        = u_imm;
            end
            default: begin
                dec.instr_type = ITYPE_NONE;
            end
        endcase
    end

endmodule

//--- mul_unit.sv
`timescale 1ns/1ns

interface mul_if import cpu_pkg::*; ();
    logic  start;
    word_t op_a;
    word_t op_b;
    logic  done;
    word_t product;

    modport mst (output start, op_a, op_b, input  done, product);
    modport slv (input  start, op_a, op_b, output done, product);
endinterface

module mul_unit import cpu_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    mul_if.slv   mul
);

    mul_cnt_t count;
    logic     busy;
    logic     accept;
    word_t    acc;
    word_t    mcand;
    word_t    mplier;
    word_t    addend;

    assign busy   = (count != '0);
    assign accept = mul.start && !busy;

    // partial sum including the current step, final on the last step
    assign addend      = mplier[0] ? mcand : '0;
    assign mul.product = acc + addend;
    assign mul.done    = (count == mul_cnt_t'(1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (accept) begin
            count <= mul_cnt_t'(MUL_STEPS);
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    // one multiplier bit per cycle, low 32 bits only
    always_ff @(posedge clk) begin
        if (accept) begin
            acc    <= '0;
            mcand  <= mul.op_a;
            mplier <= mul.op_b;
        end else if (busy) begin
            acc    <= mul.product;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_done_after_start: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(mul.done) |-> $past(accept, MUL_STEPS));

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t wr_idx,
    input  logic     wr_en,
    input  word_t    wr_data,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [NUM_REGS];

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (rs1_idx != '0 || rs1_data == '0) && (rs2_idx != '0 || rs2_data == '0));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_cpu -f compile.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Simulation failed" "$log_file"; then
    echo "FAIL: see $log_file"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "FAIL: simulator exited with status $run_status"
    exit 1
fi
echo "PASS"
exit 0

//--- tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*; ();

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_RUN,
        OP_WAIT
    } op_e;

    typedef struct packed {
        op_e       op;
        apb_addr_t addr;
        word_t     wdata;
        word_t     exp_rdata;
        logic      exp_slverr;
    } entry_t;

    logic      clk;
    logic      arst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    entry_t stim_q[$];
    int     pc_cursor;
    int     instr_total;
    int     watchdog_cycles;
    bit     table_ready = 1'b0;
    integer seed;
    word_t  mul_a;
    word_t  mul_b;

    cpu_top UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // RV32 encoders for the supported subset
    function automatic word_t addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPCODE_ALU_IMM};
    endfunction

    function automatic word_t add(input int rd, input int rs1, input int rs2);
        return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPCODE_ALU};
    endfunction

    function automatic word_t sub(input int rd, input int rs1, input int rs2);
        return {SUB_FUNCT7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPCODE_ALU};
    endfunction

    function automatic word_t mul(input int rd, input int rs1, input int rs2);
        return {MUL_FUNCT7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPCODE_ALU};
    endfunction

    function automatic word_t lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OPCODE_LOAD};
    endfunction

    function automatic word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPCODE_STORE};
    endfunction

    function automatic word_t beq(input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], BEQ_FUNCT3, imm[4:1], imm[11],
                OPCODE_BRANCH};
    endfunction

    function automatic word_t jal(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPCODE_JUMP};
    endfunction

    function automatic word_t auipc(input int rd, input int imm);
        return {imm[19:0], rd[4:0], OPCODE_AUIPC};
    endfunction

    function automatic apb_addr_t imem_byte(input int idx);
        return ADDR_IMEM_BASE + apb_addr_t'(idx * 4);
    endfunction

    function automatic apb_addr_t dmem_byte(input int idx);
        return ADDR_DMEM_BASE + apb_addr_t'(idx * 4);
    endfunction

    // marker preloaded into words a program may skip
    function automatic word_t sentinel(input int idx);
        return 32'h0bad_0000 + word_t'(idx);
    endfunction

    task automatic add_entry(input op_e op, input apb_addr_t addr, input word_t wdata,
                             input word_t exp_rdata, input logic exp_slverr);
        entry_t e;
        e.op         = op;
        e.addr       = addr;
        e.wdata      = wdata;
        e.exp_rdata  = exp_rdata;
        e.exp_slverr = exp_slverr;
        stim_q.push_back(e);
    endtask

    task automatic expect_write(input apb_addr_t addr, input word_t data, input logic err);
        add_entry(OP_WRITE, addr, data, '0, err);
    endtask

    task automatic expect_read(input apb_addr_t addr, input word_t data);
        add_entry(OP_READ, addr, '0, data, 1'b0);
    endtask

    task automatic emit(input word_t instr);
        expect_write(imem_byte(pc_cursor), instr, 1'b0);
        pc_cursor++;
        instr_total++;
    endtask

    task automatic build_table();
        word_t prod;
        word_t prod2;
        prod  = mul_a * mul_b;
        prod2 = prod * mul_a;

        // plain memory access, core idle
        expect_write(imem_byte(40), 32'h1234_5678, 1'b0);
        expect_read(imem_byte(40), 32'h1234_5678);
        expect_write(dmem_byte(50), 32'hcafe_f00d, 1'b0);
        expect_read(dmem_byte(50), 32'hcafe_f00d);

        // arithmetic program
        pc_cursor = 0;
        emit(addi(1, 0, 100));
        emit(addi(2, 0, -7));
        emit(add(3, 1, 2));
        emit(sub(4, 1, 2));
        emit(auipc(5, 1));
        emit(sw(3, 0, 0));
        emit(sw(4, 0, 4));
        emit(sw(5, 0, 8));
        emit(sw(2, 0, 12));
        emit(jal(0, 0));
        add_entry(OP_RUN, ADDR_CTRL, 32'h1, '0, 1'b0);
        expect_read(ADDR_STATUS, 32'h1);
        expect_read(dmem_byte(0), word_t'(100 + (-7)));
        expect_read(dmem_byte(1), word_t'(100 - (-7)));
        // auipc sits at byte 16
        expect_read(dmem_byte(2), word_t'(16 + (1 << 12)));
        expect_read(dmem_byte(3), word_t'(-7));
        expect_read(ADDR_PC, word_t'((pc_cursor - 1) * 4));

        // load, add offset, store to the next word
        expect_write(dmem_byte(10), 32'h1357_9bdf, 1'b0);
        expect_write(dmem_byte(11), 32'h0, 1'b0);
        pc_cursor = 0;
        emit(addi(1, 0, 40));
        emit(lw(2, 1, 0));
        emit(addi(3, 0, 'h123));
        emit(add(4, 2, 3));
        emit(sw(4, 1, 4));
        emit(jal(0, 0));
        add_entry(OP_RUN, ADDR_CTRL, 32'h1, '0, 1'b0);
        expect_read(dmem_byte(11), 32'h1357_9bdf + 32'h123);
        expect_read(dmem_byte(10), 32'h1357_9bdf);

        // branches and a linking jump
        for (int i = 20; i < 26; i++) begin
            expect_write(dmem_byte(i), sentinel(i), 1'b0);
        end
        pc_cursor = 0;
        emit(addi(1, 0, 5));
        emit(addi(2, 0, 5));
        emit(addi(3, 0, 9));
        emit(beq(1, 3, 8));
        emit(sw(1, 0, 80));
        emit(beq(1, 2, 8));
        emit(sw(1, 0, 84));
        emit(sw(3, 0, 88));
        // jal at byte 32 lands on byte 44
        emit(jal(7, 12));
        emit(sw(1, 0, 92));
        emit(sw(1, 0, 96));
        emit(sw(7, 0, 100));
        emit(jal(0, 0));
        add_entry(OP_RUN, ADDR_CTRL, 32'h1, '0, 1'b0);
        expect_read(dmem_byte(20), 32'd5);
        expect_read(dmem_byte(21), sentinel(21));
        expect_read(dmem_byte(22), 32'd9);
        expect_read(dmem_byte(23), sentinel(23));
        expect_read(dmem_byte(24), sentinel(24));
        expect_read(dmem_byte(25), 32'd32 + 32'd4);
        expect_read(ADDR_PC, 32'd48);

        // two chained MULs, memories probed while the core runs
        expect_write(dmem_byte(30), mul_a, 1'b0);
        expect_write(dmem_byte(31), mul_b, 1'b0);
        expect_write(dmem_byte(40), 32'h5a5a_a5a5, 1'b0);
        pc_cursor = 0;
        emit(lw(1, 0, 120));
        emit(lw(2, 0, 124));
        emit(mul(3, 1, 2));
        emit(mul(4, 3, 1));
        emit(sw(3, 0, 128));
        emit(sw(4, 0, 132));
        emit(jal(0, 0));
        expect_write(ADDR_CTRL, 32'h1, 1'b0);
        expect_read(ADDR_STATUS, 32'h2);
        expect_write(dmem_byte(40), 32'hdead_beef, 1'b1);
        expect_write(imem_byte(0), 32'h0, 1'b1);
        add_entry(OP_WAIT, ADDR_STATUS, '0, '0, 1'b0);
        expect_read(ADDR_STATUS, 32'h1);
        expect_read(dmem_byte(40), 32'h5a5a_a5a5);
        expect_read(imem_byte(0), lw(1, 0, 120));
        expect_read(dmem_byte(32), prod);
        expect_read(dmem_byte(33), prod2);
    endtask

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // zero wait states, so pready must be high in every access phase
    task automatic check_ready(input apb_addr_t addr, input logic got);
        assert (got === 1'b1) else begin
            $display("CHECK FAILED pready at 0x%03h: expected 0x1, got 0x%0h",
                     addr, got);
            stop_on_failure();
        end
    endtask

    // setup, access, then release on the edge that completes the transfer
    task automatic apb_xfer(input logic write, input apb_addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_ready(addr, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic check_err(input apb_addr_t addr, input logic exp, input logic got);
        assert (got === exp) else begin
            $display("CHECK FAILED pslverr at 0x%03h: expected 0x%0h, got 0x%0h",
                     addr, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic check_data(input apb_addr_t addr, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("CHECK FAILED prdata at 0x%03h: expected 0x%08h, got 0x%08h",
                     addr, exp, got);
            stop_on_failure();
        end
    endtask

    // poll status until the halted bit shows
    task automatic wait_halted();
        word_t status;
        logic  err;
        status = '0;
        while (status[0] !== 1'b1) begin
            apb_xfer(1'b0, ADDR_STATUS, '0, status, err);
            check_err(ADDR_STATUS, 1'b0, err);
        end
    endtask

    task automatic apply_entry(input entry_t e);
        word_t rdata;
        logic  err;
        case (e.op)
            OP_WRITE: begin
                apb_xfer(1'b1, e.addr, e.wdata, rdata, err);
                check_err(e.addr, e.exp_slverr, err);
            end
            OP_READ: begin
                apb_xfer(1'b0, e.addr, '0, rdata, err);
                check_err(e.addr, e.exp_slverr, err);
                check_data(e.addr, e.exp_rdata, rdata);
            end
            OP_RUN: begin
                apb_xfer(1'b1, e.addr, e.wdata, rdata, err);
                check_err(e.addr, e.exp_slverr, err);
                wait_halted();
            end
            default: wait_halted();
        endcase
    endtask

    initial begin
        wait (table_ready);
        watchdog_cycles = stim_q.size() * 40 + instr_total * 35 + 5;
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        arst_n  <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        seed        = 32'h88df_87d3;
        pc_cursor   = 0;
        instr_total = 0;
        mul_a = $random(seed);
        mul_b = $random(seed);
        build_table();
        table_ready = 1'b1;

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < stim_q.size(); i++) begin
            apply_entry(stim_q[i]);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule
